// File: Bender.yml
package:
  name: axi_rd_mst

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/axi_rd_pkg.sv
      - hw/rr_pick.sv
      - hw/rd_req_gen.sv
      - hw/rd_slot_table.sv
      - hw/rd_resp_collect.sv
      - hw/axi_rd_mst.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/axi_rd_slave_model.sv
      - testbench/tb_axi_rd_mst.sv

// File: flist.f
+incdir+hw
hw/axi_rd_pkg.sv
hw/rr_pick.sv
hw/rd_req_gen.sv
hw/rd_slot_table.sv
hw/rd_resp_collect.sv
hw/axi_rd_mst.sv
testbench/axi_rd_slave_model.sv
testbench/tb_axi_rd_mst.sv

// File: hw/axi_rd_mst.sv
// AXI4 read master top level
// Request generator, slot table and response collector

`include "axi_rd_params.svh"

module axi_rd_mst import axi_rd_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    enable,
    output logic    done,
    // AR channel
    output logic    arvalid,
    input  logic    arready,
    output ar_req_t ar,
    // R channel
    input  logic    rvalid,
    output logic    rready,
    input  r_beat_t r,
    // Completion port
    output logic    cmpl_valid,
    input  logic    cmpl_ready,
    output cmpl_t   cmpl
);

    // --------------------
    // Stage links
    // --------------------
    logic      req_valid;
    logic      req_ready;
    ar_req_t   req;
    logic      alloc_valid;
    alloc_t    alloc;
    logic      release_valid;
    slot_idx_t release_slot;

    rd_req_gen u_req_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready)
    );

    rd_slot_table u_slot_table (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .arvalid       (arvalid),
        .ar            (ar),
        .arready       (arready),
        .alloc_valid   (alloc_valid),
        .alloc         (alloc),
        .release_valid (release_valid),
        .release_slot  (release_slot)
    );

    rd_resp_collect u_resp_collect (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc_valid   (alloc_valid),
        .alloc         (alloc),
        .r_valid       (rvalid),
        .r             (r),
        .rready        (rready),
        .cmpl_valid    (cmpl_valid),
        .cmpl          (cmpl),
        .cmpl_ready    (cmpl_ready),
        .release_valid (release_valid),
        .release_slot  (release_slot),
        .done          (done)
    );

endmodule

// File: hw/axi_rd_params.svh
// Widths of the AXI4 read channels
// Slot depth, burst capacity and request count of the read master

`ifndef AXI_RD_PARAMS_SVH
`define AXI_RD_PARAMS_SVH

// --------------------
// AXI field widths
// --------------------
`define AXI_ADDR_W    32
`define AXI_DATA_W    32
`define AXI_ID_W      4
`define AXI_LEN_W     8
`define AXI_SIZE_W    3
`define AXI_BURST_W   2
`define AXI_RESP_W    2

// --------------------
// Master sizing
// --------------------
`define MAX_BURST_LEN 8     // Beats buffered per slot
`define OST_DEPTH     4     // Outstanding bursts
`define REQ_NUM       32    // Bursts per run

`endif

// File: hw/axi_rd_pkg.sv
// Types shared by the read master stages
// Burst and response encodings, AR and R payloads
// Slot allocation record and completion record

`include "axi_rd_params.svh"

package axi_rd_pkg;

    // AXI burst type encoding
    typedef enum logic [`AXI_BURST_W-1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_e;

    // Severity grows with the code, so max() is the merge
    typedef enum logic [`AXI_RESP_W-1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    typedef logic [$clog2(`OST_DEPTH)-1:0]     slot_idx_t;  // Slot number
    typedef logic [$clog2(`MAX_BURST_LEN)-1:0] beat_idx_t;  // Beat position in a slot

    // AR channel payload, 49 bits
    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_LEN_W-1:0]  len;
        logic [`AXI_SIZE_W-1:0] size;
        burst_e                 burst;
    } ar_req_t;

    // R channel payload
    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_DATA_W-1:0] data;
        resp_e                  resp;
        logic                   last;
    } r_beat_t;

    // Slot table to collector, one per accepted request
    typedef struct packed {
        slot_idx_t              slot;
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;   // Carried so the record can report it
        logic [`AXI_LEN_W-1:0]  len;
    } alloc_t;

    // Retired burst, 303 bits
    typedef struct packed {
        logic [`AXI_ID_W-1:0]                      id;
        logic [`AXI_ADDR_W-1:0]                    addr;
        logic [`AXI_LEN_W-1:0]                     len;
        resp_e                                     resp;   // Worst of all beats
        logic                                      err;    // SLVERR or DECERR seen
        logic [`MAX_BURST_LEN-1:0][`AXI_DATA_W-1:0] data;  // Word n is beat n
    } cmpl_t;

endpackage

// File: hw/rd_req_gen.sv
// Request generator of the read master
// Request counter, eight-entry burst pattern table, AR payload register

`include "axi_rd_params.svh"

module rd_req_gen import axi_rd_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    enable,
    output logic    req_valid,
    output ar_req_t req,
    input  logic    req_ready
);

    localparam int CNT_W = $clog2(`REQ_NUM);

    logic [CNT_W-1:0] req_cnt_q;    // Index of the request on offer
    logic             gen_done_q;   // All requests handed over
    logic             req_fire;
    logic             last_req;

    // --------------------
    // Pattern table
    // --------------------
    function automatic ar_req_t pattern(input logic [CNT_W-1:0] cnt);
        ar_req_t p;
        p.id   = cnt[`AXI_ID_W-1:0];
        p.size = 3'b010;                        // 4 bytes per beat
        unique case (cnt[2:0])
            3'd0: begin p.addr = 'h00; p.burst = BURST_INCR;  p.len = 8'd3; end
            3'd1: begin p.addr = 'h10; p.burst = BURST_INCR;  p.len = 8'd3; end
            3'd2: begin p.addr = 'h20; p.burst = BURST_INCR;  p.len = 8'd7; end
            3'd3: begin p.addr = 'h30; p.burst = BURST_FIXED; p.len = 8'd3; end
            3'd4: begin p.addr = 'h34; p.burst = BURST_WRAP;  p.len = 8'd3; end
            3'd5: begin p.addr = 'h38; p.burst = BURST_WRAP;  p.len = 8'd7; end
            3'd6: begin p.addr = 'h40; p.burst = BURST_FIXED; p.len = 8'd7; end
            default: begin
                // Moves 0x20 per pass through the table
                p.addr  = 'h80 + (`AXI_ADDR_W'(cnt[CNT_W-1:3]) << 5);
                p.burst = BURST_INCR;
                p.len   = 8'd3;
            end
        endcase
        return p;
    endfunction

    assign req_fire = req_valid & req_ready;
    assign last_req = (req_cnt_q == CNT_W'(`REQ_NUM - 1));

    // --------------------
    // Control
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid  <= 1'b0;
            req_cnt_q  <= '0;
            gen_done_q <= 1'b0;
        end else if (req_fire) begin
            req_cnt_q <= req_cnt_q + 1'b1;
            if (last_req) begin
                req_valid  <= 1'b0;             // Off for good
                gen_done_q <= 1'b1;
            end
        end else if (enable && !req_valid && !gen_done_q) begin
            req_valid <= 1'b1;                  // First request
        end
    end

    // Payload follows the counter one edge after each transfer
    always_ff @(posedge clk) begin
        if (req_fire) begin
            req <= pattern(req_cnt_q + 1'b1);
        end else if (!req_valid) begin
            req <= pattern(req_cnt_q);
        end
    end

endmodule

// File: hw/rd_resp_collect.sv
// Response collector of the read master
// Per-slot beat capture by ID, worst-response merge
// Round-robin completion output, slot release, done counter

`include "axi_rd_params.svh"

module rd_resp_collect import axi_rd_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      alloc_valid,
    input  alloc_t    alloc,
    // R channel
    input  logic      r_valid,
    input  r_beat_t   r,
    output logic      rready,
    // Completion port
    output logic      cmpl_valid,
    output cmpl_t     cmpl,
    input  logic      cmpl_ready,
    // Back to slot table
    output logic      release_valid,
    output slot_idx_t release_slot,
    output logic      done
);

    localparam int CNT_W = $clog2(`REQ_NUM);

    logic [`OST_DEPTH-1:0] live_q;      // Waiting for beats
    logic [`OST_DEPTH-1:0] full_q;      // rlast seen, waiting for cmpl_ready

    // Per-slot burst record
    logic [`AXI_ID_W-1:0]                       id_q       [`OST_DEPTH];
    logic [`AXI_ADDR_W-1:0]                     addr_q     [`OST_DEPTH];
    logic [`AXI_LEN_W-1:0]                      len_q      [`OST_DEPTH];
    beat_idx_t                                  beat_cnt_q [`OST_DEPTH];
    resp_e                                      resp_q     [`OST_DEPTH];
    logic [`MAX_BURST_LEN-1:0][`AXI_DATA_W-1:0] data_q     [`OST_DEPTH];

    logic [`OST_DEPTH-1:0] hit;
    slot_idx_t             hit_idx;
    logic                  r_fire;
    slot_idx_t             pick_idx;
    slot_idx_t             sel;
    logic                  cmpl_fire;
    logic                  cmpl_lock_q;
    slot_idx_t             cmpl_lock_idx_q;
    logic [CNT_W-1:0]      cmpl_cnt_q;

    assign rready = 1'b1;               // Always sinks R
    assign r_fire = r_valid & rready;

    // --------------------
    // ID match
    // --------------------
    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < `OST_DEPTH; i++) begin
            hit[i] = live_q[i] && (r.id == id_q[i]);
            if (hit[i]) begin
                hit_idx = slot_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            live_q <= '0;
            full_q <= '0;
        end else begin
            for (int i = 0; i < `OST_DEPTH; i++) begin
                if (alloc_valid && alloc.slot == slot_idx_t'(i)) begin
                    live_q[i] <= 1'b1;
                end else if (r_fire && hit[i] && r.last) begin
                    live_q[i] <= 1'b0;
                    full_q[i] <= 1'b1;  // Offered from next cycle
                end
            end
            if (cmpl_fire) begin
                full_q[sel] <= 1'b0;
            end
        end
    end

    // Record fields, reloaded on every allocation
    always_ff @(posedge clk) begin
        for (int i = 0; i < `OST_DEPTH; i++) begin
            if (alloc_valid && alloc.slot == slot_idx_t'(i)) begin
                id_q[i]       <= alloc.id;
                addr_q[i]     <= alloc.addr;
                len_q[i]      <= alloc.len;
                beat_cnt_q[i] <= '0;
                resp_q[i]     <= RESP_OKAY;
            end else if (r_fire && hit[i]) begin
                data_q[i][beat_cnt_q[i]] <= r.data;
                beat_cnt_q[i]            <= beat_cnt_q[i] + 1'b1;
                resp_q[i]                <= (r.resp > resp_q[i]) ? r.resp : resp_q[i];
            end
        end
    end

    // --------------------
    // Completion output
    // --------------------
    rr_pick #(.N(`OST_DEPTH)) u_cmpl_pick (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (full_q),
        .take      (cmpl_fire),
        .grant_idx (pick_idx),
        .grant_any (cmpl_valid)
    );

    // Offered record stays put until accepted
    assign sel       = cmpl_lock_q ? cmpl_lock_idx_q : pick_idx;
    assign cmpl_fire = cmpl_valid & cmpl_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmpl_lock_q <= 1'b0;
        end else begin
            cmpl_lock_q <= cmpl_valid & ~cmpl_ready;
        end
    end

    always_ff @(posedge clk) begin
        cmpl_lock_idx_q <= sel;
    end

    assign cmpl.id   = id_q[sel];
    assign cmpl.addr = addr_q[sel];
    assign cmpl.len  = len_q[sel];
    assign cmpl.resp = resp_q[sel];
    assign cmpl.err  = (resp_q[sel] == RESP_SLVERR) || (resp_q[sel] == RESP_DECERR);
    assign cmpl.data = data_q[sel];

    assign release_valid = cmpl_fire;   // Slot frees once retired
    assign release_slot  = sel;

    // --------------------
    // Retirement count
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmpl_cnt_q <= '0;
            done       <= 1'b0;
        end else if (cmpl_fire) begin
            cmpl_cnt_q <= cmpl_cnt_q + 1'b1;
            if (cmpl_cnt_q == CNT_W'(`REQ_NUM - 1)) begin
                done <= 1'b1;
            end
        end
    end

    // Each beat belongs to exactly one issued burst
    a_r_one_slot: assert property (@(posedge clk) disable iff (!rst_n)
        r_fire |-> $onehot(hit));

    // rlast on beat len+1, never earlier or later
    a_rlast_pos: assert property (@(posedge clk) disable iff (!rst_n)
        r_fire |-> (r.last == (`AXI_LEN_W'(beat_cnt_q[hit_idx]) == len_q[hit_idx])));

endmodule

// File: hw/rd_slot_table.sv
// Outstanding slot table of the read master
// Free slot allocation, round-robin AR issue, slot release
// Stall lock keeping AR stable under back-pressure

`include "axi_rd_params.svh"

module rd_slot_table import axi_rd_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    // Request in
    input  logic      req_valid,
    input  ar_req_t   req,
    output logic      req_ready,
    // AR channel
    output logic      arvalid,
    output ar_req_t   ar,
    input  logic      arready,
    // Collector side
    output logic      alloc_valid,
    output alloc_t    alloc,
    input  logic      release_valid,
    input  slot_idx_t release_slot
);

    logic [`OST_DEPTH-1:0] busy_q;      // Slot holds a live burst
    logic [`OST_DEPTH-1:0] pending_q;   // AR not yet accepted
    ar_req_t               slot_req_q [`OST_DEPTH];

    slot_idx_t free_idx;
    logic      free_any;
    slot_idx_t pick_idx;
    slot_idx_t issue_idx;
    logic      req_fire;
    logic      ar_fire;
    logic      ar_lock_q;               // AR stalled last cycle
    slot_idx_t ar_lock_idx_q;

    // --------------------
    // Allocation
    // --------------------
    rr_pick #(.N(`OST_DEPTH)) u_free_pick (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (~busy_q),
        .take      (req_fire),
        .grant_idx (free_idx),
        .grant_any (free_any)
    );

    assign req_ready = free_any;        // Any empty slot
    assign req_fire  = req_valid & req_ready;

    assign alloc_valid = req_fire;      // Collector registers it at the same edge
    assign alloc.slot  = free_idx;
    assign alloc.id    = req.id;
    assign alloc.addr  = req.addr;
    assign alloc.len   = req.len;

    // --------------------
    // AR issue
    // --------------------
    rr_pick #(.N(`OST_DEPTH)) u_issue_pick (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (pending_q),
        .take      (ar_fire),
        .grant_idx (pick_idx),
        .grant_any (arvalid)
    );

    // A stalled AR keeps its slot even if a nearer one turns pending
    assign issue_idx = ar_lock_q ? ar_lock_idx_q : pick_idx;
    assign ar        = slot_req_q[issue_idx];
    assign ar_fire   = arvalid & arready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_lock_q <= 1'b0;
        end else begin
            ar_lock_q <= arvalid & ~arready;
        end
    end

    always_ff @(posedge clk) begin
        ar_lock_idx_q <= issue_idx;
    end

    // --------------------
    // Slot state
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q    <= '0;
            pending_q <= '0;
        end else begin
            if (req_fire) begin
                busy_q[free_idx]    <= 1'b1;
                pending_q[free_idx] <= 1'b1;
            end
            if (ar_fire) begin
                pending_q[issue_idx] <= 1'b0;
            end
            if (release_valid) begin
                busy_q[release_slot] <= 1'b0;   // Free from next edge
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            slot_req_q[free_idx] <= req;
        end
    end

    // Stalled AR must not change
    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(ar));

    // Collector only retires slots this table handed out
    a_release_busy: assert property (@(posedge clk) disable iff (!rst_n)
        release_valid |-> busy_q[release_slot]);

endmodule

// File: hw/rr_pick.sv
// Round-robin picker
// Grants the first requester at or after a rotating pointer

module rr_pick #(
    parameter int N = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [N-1:0]                         req,
    input  logic                                 take,
    output logic [((N > 1) ? $clog2(N) : 1)-1:0] grant_idx,
    output logic                                 grant_any
);

    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    logic [IDX_W-1:0] ptr_q;    // Highest priority position

    // Scan downward so the nearest requester wins
    always_comb begin
        int unsigned pos;
        grant_any = 1'b0;
        grant_idx = ptr_q;
        for (int i = N - 1; i >= 0; i--) begin
            pos = (int'(ptr_q) + i) % N;
            if (req[pos]) begin
                grant_any = 1'b1;
                grant_idx = IDX_W'(pos);
            end
        end
    end

    // Step past the winner once it is served
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr_q <= '0;
        end else if (take && grant_any) begin
            ptr_q <= (int'(grant_idx) == N - 1) ? '0 : grant_idx + 1'b1;
        end
    end

endmodule

// File: testbench/axi_rd_slave_model.sv
// AXI4 read slave model for the read master testbench
// AR acceptance with per-request stall cycles from the testdata
// R beats served from a burst queue, data equals the beat byte address

`include "axi_rd_params.svh"

module axi_rd_slave_model import axi_rd_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    arvalid,
    output logic    arready,
    input  ar_req_t ar,
    output logic    rvalid,
    input  logic    rready,
    output r_beat_t r
);

    localparam int TD_COLS = 6;     // addr len burst resp stall ooo

    logic [31:0] td [`REQ_NUM*TD_COLS];
    ar_req_t     burst_q [$];       // Accepted, not yet served
    int          idx_q [$];         // Request index per queued burst
    int          ar_cnt;
    int          stall_cnt;

    initial begin
        $readmemh("testbench/axi_rd_testdata.txt", td);
    end

    // --------------------
    // AR acceptance
    // --------------------
    initial begin
        arready   = 1'b0;
        ar_cnt    = 0;
        stall_cnt = 0;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            if (arvalid && arready) begin
                burst_q.push_back(ar);
                idx_q.push_back(ar_cnt);
                ar_cnt++;
                stall_cnt = 0;
            end else if (arvalid) begin
                stall_cnt++;                // Cycles this AR waited
            end
            #10;
            arready = (ar_cnt < `REQ_NUM) && (stall_cnt >= int'(td[ar_cnt*TD_COLS+4]));
        end
    end

    // --------------------
    // R beats
    // --------------------
    initial begin
        ar_req_t                cur;
        int                     cur_idx;
        int                     pick;
        int                     beat;
        int                     span;
        logic                   active;
        logic [`AXI_ADDR_W-1:0] addr;
        rvalid  = 1'b0;
        r       = '0;
        cur     = '0;
        cur_idx = 0;
        beat    = 0;
        active  = 1'b0;
        addr    = '0;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            if (rvalid && rready) begin
                if (r.last) begin
                    active = 1'b0;
                end
                beat++;
                // Step to the next beat address
                span = (int'(cur.len) + 1) * 4;
                if (cur.burst == BURST_INCR) begin
                    addr = addr + 4;
                end else if (cur.burst == BURST_WRAP) begin
                    addr = addr + 4;
                    if (addr % span == 0) begin
                        addr = addr - span;  // Back to window start
                    end
                end
            end
            #10;
            if (!active && burst_q.size() > 0) begin
                // Newest first when its ooo flag is set
                pick = 0;
                if (burst_q.size() > 1 && td[idx_q[$]*TD_COLS+5] != 0) begin
                    pick = burst_q.size() - 1;
                end
                cur     = burst_q[pick];
                cur_idx = idx_q[pick];
                burst_q.delete(pick);
                idx_q.delete(pick);
                active = 1'b1;
                beat   = 0;
                addr   = cur.addr;
            end
            rvalid = active;
            r.id   = cur.id;
            r.data = addr;
            r.resp = resp_e'(td[cur_idx*TD_COLS+3][1:0]);  // Same code on every beat
            r.last = (beat == int'(cur.len));
        end
    end

endmodule

// File: testbench/axi_rd_testdata.txt
// One line per request: araddr arlen arburst(0 FIXED 1 INCR 2 WRAP)
// then rresp returned, arready stall cycles, serve-newest-first flag
00000000 03 1 0 0 0
00000010 03 1 0 1 0
00000020 07 1 1 0 0
00000030 03 0 0 2 0
00000034 03 2 2 0 0
00000038 07 2 0 0 1
00000040 07 0 0 1 0
00000080 03 1 3 0 0
00000000 03 1 0 3 0
00000010 03 1 2 0 1
00000020 07 1 0 0 0
00000030 03 0 1 1 0
00000034 03 2 0 0 1
00000038 07 2 0 2 0
00000040 07 0 3 0 0
000000a0 03 1 0 0 1
00000000 03 1 0 1 0
00000010 03 1 0 0 0
00000020 07 1 2 0 1
00000030 03 0 0 3 0
00000034 03 2 1 0 0
00000038 07 2 0 1 0
00000040 07 0 0 0 1
000000c0 03 1 2 2 0
00000000 03 1 0 0 0
00000010 03 1 3 1 0
00000020 07 1 0 0 1
00000030 03 0 0 0 0
00000034 03 2 0 2 1
00000038 07 2 1 0 0
00000040 07 0 0 0 0
000000e0 03 1 2 1 0

// File: testbench/tb_axi_rd_mst.sv
// Testbench for the AXI4 read master
// Clock, reset, random completion back-pressure
// AR, completion and done checks against the testdata, timeout and verdict

`include "axi_rd_params.svh"

module tb_axi_rd_mst import axi_rd_pkg::*; ();

    localparam int TD_COLS   = 6;
    localparam int MAX_CYCLE = `REQ_NUM * 40;

    logic    clk;
    logic    rst_n;
    logic    enable;
    logic    done;
    logic    arvalid;
    logic    arready;
    ar_req_t ar;
    logic    rvalid;
    logic    rready;
    r_beat_t r;
    logic    cmpl_valid;
    logic    cmpl_ready;
    cmpl_t   cmpl;

    logic [31:0]         td [`REQ_NUM*TD_COLS];
    logic [`REQ_NUM-1:0] issued;        // AR handshake seen
    logic [`REQ_NUM-1:0] retired;       // Completion accepted
    int                  n_issued;
    int                  n_retired;
    int                  cycle_cnt;
    integer              seed;
    logic                cmpl_held_q;   // Completion stalled last edge
    cmpl_t               cmpl_hold;

    axi_rd_mst DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .enable     (enable),
        .done       (done),
        .arvalid    (arvalid),
        .arready    (arready),
        .ar         (ar),
        .rvalid     (rvalid),
        .rready     (rready),
        .r          (r),
        .cmpl_valid (cmpl_valid),
        .cmpl_ready (cmpl_ready),
        .cmpl       (cmpl)
    );

    axi_rd_slave_model u_slave (
        .clk     (clk),
        .rst_n   (rst_n),
        .arvalid (arvalid),
        .arready (arready),
        .ar      (ar),
        .rvalid  (rvalid),
        .rready  (rready),
        .r       (r)
    );

    always #50 clk = ~clk;

    // --------------------
    // Helpers
    // --------------------
    task automatic stop_with(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_with($sformatf("Error: %s got %h expected %h", name, got, exp));
    endtask

    // Byte address of beat n, 4-byte beats
    function automatic logic [31:0] beat_addr(input logic [31:0] start, input logic [7:0] len,
                                              input burst_e burst, input int n);
        logic [31:0] span;
        logic [31:0] base;
        span = (32'(len) + 1) * 4;
        base = start & ~(span - 1);
        case (burst)
            BURST_FIXED: return start;
            BURST_WRAP:  return base + ((start - base + 32'(n) * 4) % span);
            default:     return start + 32'(n) * 4;
        endcase
    endfunction

    // AR in request order, never more than OST_DEPTH in flight
    task automatic check_ar();
        int b;
        b = n_issued * TD_COLS;
        assert (n_issued < `REQ_NUM) else stop_with("AR handshake after the last request");
        assert (n_issued - n_retired < `OST_DEPTH)
            else stop_with("AR issued while OST_DEPTH bursts were already outstanding");
        assert (ar.addr == td[b]) else report_mismatch("ar.addr", ar.addr, td[b]);
        assert (ar.len == td[b+1][7:0]) else report_mismatch("ar.len", ar.len, td[b+1]);
        assert (ar.burst == td[b+2][1:0]) else report_mismatch("ar.burst", ar.burst, td[b+2]);
        assert (ar.size == 3'd2) else report_mismatch("ar.size", ar.size, 2);
        assert (ar.id == 4'(n_issued)) else report_mismatch("ar.id", ar.id, 4'(n_issued));
        issued[n_issued] = 1'b1;
        n_issued++;
    endtask

    task automatic check_cmpl();
        int          k;
        logic [1:0]  exp_resp;
        logic [31:0] exp_word;
        logic [7:0]  exp_len;
        k = -1;
        // Oldest issued, unretired request with this id
        for (int i = 0; i < `REQ_NUM; i++) begin
            if (k < 0 && issued[i] && !retired[i] && 4'(i) == cmpl.id) begin
                k = i;
            end
        end
        assert (k >= 0)
            else stop_with($sformatf("Completion with id %h matches no outstanding request",
                                     cmpl.id));
        exp_resp = td[k*TD_COLS+3][1:0];
        exp_len  = td[k*TD_COLS+1][7:0];
        assert (cmpl.addr == td[k*TD_COLS])
            else report_mismatch("cmpl.addr", cmpl.addr, td[k*TD_COLS]);
        assert (cmpl.len == exp_len)
            else report_mismatch("cmpl.len", cmpl.len, td[k*TD_COLS+1]);
        assert (cmpl.resp == exp_resp) else report_mismatch("cmpl.resp", cmpl.resp, exp_resp);
        assert (cmpl.err == (exp_resp >= 2)) else report_mismatch("cmpl.err", cmpl.err, !cmpl.err);
        for (int n = 0; n <= int'(exp_len); n++) begin
            exp_word = beat_addr(td[k*TD_COLS], exp_len,
                                 burst_e'(td[k*TD_COLS+2][1:0]), n);
            assert (cmpl.data[n] == exp_word)
                else report_mismatch($sformatf("cmpl.data[%0d]", n), cmpl.data[n], exp_word);
        end
        retired[k] = 1'b1;
        n_retired++;
    endtask

    // --------------------
    // Monitor
    // --------------------
    always @(posedge clk) begin
        if (rst_n) begin
            assert (cycle_cnt < MAX_CYCLE)
                else stop_with("Timeout: the run did not retire all requests in time");
            assert (done == (n_retired == `REQ_NUM))
                else report_mismatch("done", done, n_retired == `REQ_NUM);
            assert (rready == 1'b1) else report_mismatch("rready", rready, 1);
            if (cmpl_held_q) begin
                assert (cmpl_valid && cmpl == cmpl_hold)
                    else stop_with("Completion changed or dropped while cmpl_ready was low");
            end
            if (arvalid && arready) begin
                check_ar();
            end
            if (cmpl_valid && cmpl_ready) begin
                check_cmpl();
            end
            cmpl_held_q = cmpl_valid && !cmpl_ready;
            cmpl_hold   = cmpl;
            cycle_cnt++;
        end
    end

    // Random cmpl_ready, withheld for a window to fill the slots
    initial begin
        seed       = 32'h16f1_ea31;
        cmpl_ready = 1'b0;
        forever begin
            @(posedge clk);
            #10;
            if (cycle_cnt >= 60 && cycle_cnt < 120) begin
                cmpl_ready = 1'b0;
            end else begin
                cmpl_ready = ($random(seed) & 3) != 0;
            end
        end
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        enable      = 1'b0;
        issued      = '0;
        retired     = '0;
        n_issued    = 0;
        n_retired   = 0;
        cycle_cnt   = 0;
        cmpl_held_q = 1'b0;
        cmpl_hold   = '0;
        $readmemh("testbench/axi_rd_testdata.txt", td);
        repeat (3) @(posedge clk);
        #10;
        rst_n = 1'b1;
        @(posedge clk);
        #10;
        enable = 1'b1;
        wait (n_retired == `REQ_NUM);
        repeat (4) @(posedge clk);      // done must stay high
        if (n_issued == `REQ_NUM && done) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            stop_with("Run ended with requests not issued or done low");
        end
    end

endmodule
